// ==== common/pano_config.svh ====
`ifndef PANO_CONFIG_SVH
`define PANO_CONFIG_SVH

// ------------------------------------------------------------
// Memory map
// ------------------------------------------------------------

// Internal RAM, 8 KB echoed across the top 64 KB
`define PANO_RAM_BASE   32'hFFFF0000
`define PANO_RAM_WORDS  2048

// GPIO register block
`define PANO_GPIO_BASE  32'h03000000
`define PANO_GPIO_SIZE  256

// Word index of the audio sample register
`define PANO_GPIO_SAMPLE_IDX 4

// ------------------------------------------------------------
// Audio path
// ------------------------------------------------------------

// Frames buffered between bus and serializer
`define PANO_FIFO_DEPTH 4

// clk_rv cycles per serial bit
`define PANO_BCLK_DIV   4

// Bits per DSP frame, both channels
`define PANO_FRAME_BITS 32

`endif

// ==== common/pano_pkg.sv ====
package pano_pkg;

    // ------------------------------------------------------------
    // PicoRV32 native memory bus
    // ------------------------------------------------------------

    // Request held by the master until ready, nonzero wstrb is a write
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } bus_req_t;

    // Ready is a single-cycle pulse with rdata valid alongside
    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
    } bus_rsp_t;

    // Address regions seen by the decoder
    typedef enum logic [2:0] {
        REGION_NONE = 3'd0,
        REGION_RAM  = 3'd1,
        REGION_GPIO = 3'd2
    } region_e;

    // ------------------------------------------------------------
    // Audio
    // ------------------------------------------------------------

    // Stereo sample pair, left sits in the upper half and goes out first
    typedef struct packed {
        logic [15:0] left;
        logic [15:0] right;
    } audio_frame_t;

endpackage

// ==== verilog/soc_bus_decoder.sv ====
`include "pano_config.svh"

module soc_bus_decoder (
    input  logic               clk_rv,
    input  logic               vb_rst,
    input  pano_pkg::bus_req_t req,
    output pano_pkg::bus_rsp_t rsp,
    output logic               ram_sel,
    output logic               gpio_sel,
    input  logic [31:0]        ram_rdata,
    input  logic [31:0]        gpio_rdata,
    input  logic               gpio_stall,
    output logic               irq
);
    import pano_pkg::*;

    localparam logic [31:0] GPIO_END = `PANO_GPIO_BASE + 32'(`PANO_GPIO_SIZE);

    region_e     region_d;
    region_e     region_q;
    logic        busy;
    logic        accept;
    logic        ready;
    logic [31:0] rdata;

    // ------------------------------------------------------------
    // Address decode, latched in the first cycle of a request
    // ------------------------------------------------------------
    always_comb begin
        if (req.addr >= `PANO_RAM_BASE) begin
            region_d = REGION_RAM;
        end else if ((req.addr >= `PANO_GPIO_BASE) && (req.addr < GPIO_END)) begin
            region_d = REGION_GPIO;
        end else begin
            region_d = REGION_NONE;
        end
    end

    // A valid without a pending request starts a new access
    assign accept = req.valid && !busy;

    always_ff @(posedge clk_rv or posedge vb_rst) begin
        if (vb_rst) begin
            busy     <= 1'b0;
            region_q <= REGION_NONE;
            irq      <= 1'b0;
        end else begin
            if (accept) begin
                busy     <= 1'b1;
                region_q <= region_d;
            end else if (ready) begin
                busy <= 1'b0;
            end
            // Fault stays up until reset
            if (accept && (region_d == REGION_NONE)) begin
                irq <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Selects, ready and read data
    // ------------------------------------------------------------
    assign ram_sel  = busy && (region_q == REGION_RAM);
    assign gpio_sel = busy && (region_q == REGION_GPIO);

    // GPIO holds ready back while the sample FIFO is full
    assign ready = busy && !(gpio_sel && gpio_stall);

    always_comb begin
        case (region_q)
            REGION_RAM:  rdata = ram_rdata;
            REGION_GPIO: rdata = gpio_rdata;
            default:     rdata = 32'hFFFFFFFF;
        endcase
    end

    assign rsp = '{ready: ready, rdata: rdata};

    // Master keeps valid up through the whole access
    a_ready_needs_valid: assert property (
        @(posedge clk_rv) disable iff (vb_rst)
        ready |-> (req.valid && $past(req.valid))
    );

endmodule

// ==== verilog/soc_ram.sv ====
`include "pano_config.svh"

module soc_ram (
    input  logic               clk_rv,
    input  logic               sel,
    input  pano_pkg::bus_req_t req,
    output logic [31:0]        rdata
);

    localparam int IDX_W = $clog2(`PANO_RAM_WORDS);

    logic [31:0]      mem [`PANO_RAM_WORDS];
    logic [IDX_W-1:0] idx;

    // Upper address bits ignored, so the RAM echoes across its window
    assign idx = req.addr[IDX_W+1:2];

    always_ff @(posedge clk_rv) begin
        for (int b = 0; b < 4; b++) begin
            if (sel && req.wstrb[b]) begin
                mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
            end
        end
        // Read every cycle, ready for the second cycle of the access
        rdata <= mem[idx];
    end

endmodule

// ==== gpio/gpio_regs.sv ====
`include "pano_config.svh"

module gpio_regs (
    input  logic                   clk_rv,
    input  logic                   vb_rst,
    input  logic                   sel,
    input  pano_pkg::bus_req_t     req,
    output logic [31:0]            rdata,
    output logic                   stall,
    output logic                   led_red_n,
    output logic                   led_green_n,
    output logic                   core_hold,
    output logic [7:0]             key,
    output pano_pkg::audio_frame_t frame,
    output logic                   push,
    input  logic                   fifo_full
);

    localparam int IDX_W = $clog2(`PANO_GPIO_SIZE) - 2;

    localparam logic [IDX_W-1:0] IDX_GREEN  = IDX_W'(0);
    localparam logic [IDX_W-1:0] IDX_RED    = IDX_W'(1);
    localparam logic [IDX_W-1:0] IDX_HOLD   = IDX_W'(2);
    localparam logic [IDX_W-1:0] IDX_KEY    = IDX_W'(3);
    localparam logic [IDX_W-1:0] IDX_SAMPLE = IDX_W'(`PANO_GPIO_SAMPLE_IDX);

    logic [IDX_W-1:0] idx;
    logic             wr;
    logic             sample_wr;
    logic             led_green;
    logic             led_red;

    assign idx       = req.addr[IDX_W+1:2];
    assign wr        = sel && (req.wstrb != 4'd0);
    assign sample_wr = wr && (idx == IDX_SAMPLE);

    // ------------------------------------------------------------
    // Control registers
    // ------------------------------------------------------------
    always_ff @(posedge clk_rv or posedge vb_rst) begin
        if (vb_rst) begin
            led_green <= 1'b0;
            led_red   <= 1'b0;
            core_hold <= 1'b1;
            key       <= 8'd0;
        end else if (wr) begin
            case (idx)
                IDX_GREEN: led_green <= req.wdata[0];
                IDX_RED:   led_red   <= req.wdata[0];
                IDX_HOLD:  core_hold <= req.wdata[0];
                IDX_KEY:   key       <= req.wdata[7:0];
                default:   ;
            endcase
        end
    end

    always_comb begin
        case (idx)
            IDX_GREEN: rdata = {31'd0, led_green};
            IDX_RED:   rdata = {31'd0, led_red};
            IDX_HOLD:  rdata = {31'd0, core_hold};
            IDX_KEY:   rdata = {24'd0, key};
            default:   rdata = 32'd0;
        endcase
    end

    // LEDs are active low on the board
    assign led_green_n = !led_green;
    assign led_red_n   = !led_red;

    // ------------------------------------------------------------
    // Audio sample port
    // ------------------------------------------------------------
    assign frame = '{left: req.wdata[31:16], right: req.wdata[15:0]};

    // Wait here until the FIFO has room, then push once
    assign push  = sample_wr && !fifo_full;
    assign stall = sample_wr && fifo_full;

endmodule

// ==== audio/sample_fifo.sv ====
module sample_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                   clk_rv,
    input  logic                   vb_rst,
    input  logic                   push,
    input  pano_pkg::audio_frame_t din,
    output logic                   full,
    input  logic                   pop,
    output pano_pkg::audio_frame_t dout,
    output logic                   empty
);
    import pano_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

    audio_frame_t     mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == CNT_FULL);
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Head of the buffer is always visible
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk_rv) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    // ------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------
    always_ff @(posedge clk_rv or posedge vb_rst) begin
        if (vb_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // GPIO must stall rather than overrun
    a_no_push_full: assert property (
        @(posedge clk_rv) disable iff (vb_rst) push |-> !full
    );

    // Serializer sends silence instead of popping an empty buffer
    a_no_pop_empty: assert property (
        @(posedge clk_rv) disable iff (vb_rst) pop |-> !empty
    );

endmodule

// ==== audio/dsp_serializer.sv ====
`include "pano_config.svh"

module dsp_serializer (
    input  logic                   clk_rv,
    input  logic                   vb_rst,
    input  pano_pkg::audio_frame_t frame,
    input  logic                   empty,
    output logic                   pop,
    output logic                   bclk,
    output logic                   lrck,
    output logic                   dat
);

    localparam int FRAME_W = `PANO_FRAME_BITS;
    localparam int PHASE_W = $clog2(`PANO_BCLK_DIV);
    localparam int BIT_W   = $clog2(FRAME_W);

    localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(`PANO_BCLK_DIV - 1);
    localparam logic [PHASE_W-1:0] PHASE_RISE = PHASE_W'(`PANO_BCLK_DIV / 2);
    localparam logic [BIT_W-1:0]   BIT_LAST   = BIT_W'(FRAME_W - 1);

    logic [PHASE_W-1:0] phase;
    logic [BIT_W-1:0]   bits_left;
    logic [FRAME_W-1:0] shift_q;
    logic               frame_start;

    // Frame boundary falls on phase 0 once the last bit is done
    assign frame_start = (phase == '0) && (bits_left == '0);
    assign pop         = frame_start && !empty;

    // ------------------------------------------------------------
    // DSP mode B bit engine
    // ------------------------------------------------------------
    always_ff @(posedge clk_rv or posedge vb_rst) begin
        if (vb_rst) begin
            phase     <= '0;
            bits_left <= '0;
            shift_q   <= '0;
            bclk      <= 1'b0;
            lrck      <= 1'b0;
        end else begin
            phase <= (phase == PHASE_LAST) ? '0 : phase + 1'b1;
            if (phase == '0) begin
                // Falling edge of bclk, data moves here
                bclk <= 1'b0;
                if (bits_left == '0) begin
                    bits_left <= BIT_LAST;
                    lrck      <= 1'b1;
                    shift_q   <= empty ? '0 : frame;
                end else begin
                    bits_left <= bits_left - 1'b1;
                    lrck      <= 1'b0;
                    shift_q   <= {shift_q[FRAME_W-2:0], 1'b0};
                end
            end else if (phase == PHASE_RISE) begin
                bclk <= 1'b1;
            end
        end
    end

    // MSB first, so left channel leads
    assign dat = shift_q[FRAME_W-1];

endmodule

// ==== verilog/pano_soc_top.sv ====
`include "pano_config.svh"

module pano_soc_top (
    input  logic               clk_rv,
    input  logic               vb_rst,
    input  pano_pkg::bus_req_t req,
    output pano_pkg::bus_rsp_t rsp,
    output logic               irq,
    output logic               led_red_n,
    output logic               led_green_n,
    output logic               core_hold,
    output logic [7:0]         key,
    output logic               audio_bclk,
    output logic               audio_lrck,
    output logic               audio_dat
);
    import pano_pkg::*;

    logic         ram_sel;
    logic         gpio_sel;
    logic [31:0]  ram_rdata;
    logic [31:0]  gpio_rdata;
    logic         gpio_stall;
    audio_frame_t push_frame;
    audio_frame_t head_frame;
    logic         fifo_push;
    logic         fifo_full;
    logic         fifo_pop;
    logic         fifo_empty;

    // ------------------------------------------------------------
    // Bus fabric
    // ------------------------------------------------------------
    soc_bus_decoder u_decoder (
        .clk_rv     (clk_rv),
        .vb_rst     (vb_rst),
        .req        (req),
        .rsp        (rsp),
        .ram_sel    (ram_sel),
        .gpio_sel   (gpio_sel),
        .ram_rdata  (ram_rdata),
        .gpio_rdata (gpio_rdata),
        .gpio_stall (gpio_stall),
        .irq        (irq)
    );

    soc_ram u_ram (
        .clk_rv (clk_rv),
        .sel    (ram_sel),
        .req    (req),
        .rdata  (ram_rdata)
    );

    gpio_regs u_gpio (
        .clk_rv      (clk_rv),
        .vb_rst      (vb_rst),
        .sel         (gpio_sel),
        .req         (req),
        .rdata       (gpio_rdata),
        .stall       (gpio_stall),
        .led_red_n   (led_red_n),
        .led_green_n (led_green_n),
        .core_hold   (core_hold),
        .key         (key),
        .frame       (push_frame),
        .push        (fifo_push),
        .fifo_full   (fifo_full)
    );

    // ------------------------------------------------------------
    // Audio path
    // ------------------------------------------------------------
    sample_fifo #(
        .DEPTH (`PANO_FIFO_DEPTH)
    ) u_fifo (
        .clk_rv (clk_rv),
        .vb_rst (vb_rst),
        .push   (fifo_push),
        .din    (push_frame),
        .full   (fifo_full),
        .pop    (fifo_pop),
        .dout   (head_frame),
        .empty  (fifo_empty)
    );

    dsp_serializer u_serializer (
        .clk_rv (clk_rv),
        .vb_rst (vb_rst),
        .frame  (head_frame),
        .empty  (fifo_empty),
        .pop    (fifo_pop),
        .bclk   (audio_bclk),
        .lrck   (audio_lrck),
        .dat    (audio_dat)
    );

endmodule

// ==== tests/pano_soc_tb.sv ====
`include "pano_config.svh"

module pano_soc_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import pano_pkg::*;

    localparam int BUS_TIMEOUT   = 1000;
    localparam int DRAIN_TIMEOUT = 8000;

    logic               clk_rv = 1'b0;
    logic               vb_rst = 1'b1;
    bus_req_t           req    = '0;
    bus_rsp_t           rsp;
    logic               irq;
    logic               led_red_n;
    logic               led_green_n;
    logic               core_hold;
    logic [7:0]         key;
    logic               audio_bclk;
    logic               audio_lrck;
    logic               audio_dat;

    logic [31:0]  lfsr = 32'h323716d8;
    int           error_count;
    int           check_count;
    logic [31:0]  ram_model [`PANO_RAM_WORDS];
    logic [7:0]   gpio_model [4];
    audio_frame_t exp_q [$];
    logic [31:0]  shift_word;
    int           bit_count;
    int           frames_seen;
    logic [31:0]  last_frame;
    event         timeout_ev;

    pano_soc_top dut_i (.*);

    always #5 clk_rv = !clk_rv;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA3000000) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Hand the end of the run to the watcher and park here
    task automatic timeout_fail(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        -> timeout_ev;
        forever @(posedge clk_rv);
    endtask

    initial begin
        @(timeout_ev);
        $display("checks=%0d errors=%0d", check_count, error_count + 1);
        $display("Finished with errors");
        $finish;
    end

    // One bus access, ends at the negedge where ready is seen
    task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] wstrb, output logic [31:0] rdata,
                              output int cycles);
        @(posedge clk_rv);
        req <= '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
        // Cycles counted after the first one of the request
        cycles = 0;
        @(negedge clk_rv);
        while (!rsp.ready && cycles < BUS_TIMEOUT) begin
            @(negedge clk_rv);
            cycles++;
        end
        if (!rsp.ready) timeout_fail("rsp.ready");
        rdata = rsp.rdata;
    endtask

    task automatic bus_idle();
        @(posedge clk_rv);
        req.valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_TIMEOUT) begin
            @(negedge clk_rv);
            n++;
        end
        if (exp_q.size() != 0) timeout_fail("audio frames to drain");
        // Two more frames, so a duplicate would still show up
        repeat (2 * 128) @(negedge clk_rv);
    endtask

    // ------------------------------------------------------------
    // Serial audio decoder
    // ------------------------------------------------------------
    initial begin
        bit_count   = 0;
        frames_seen = 0;
        shift_word  = '0;
    end

    always @(posedge audio_bclk) begin
        if (audio_lrck) begin
            shift_word = {31'd0, audio_dat};
            bit_count  = 1;
        end else begin
            shift_word = {shift_word[30:0], audio_dat};
            bit_count++;
        end
        if (bit_count == 32) begin
            frames_seen++;
            last_frame = shift_word;
            // Zero frames are silence, others must follow the written order
            if (shift_word != 32'd0) begin
                check_count++;
                assert (exp_q.size() != 0) else begin
                    error_count++;
                    $display("frame %h came out with no frame pending at %0t",
                             shift_word, $time);
                end
                if (exp_q.size() != 0) begin
                    check_value("audio frame", shift_word, exp_q.pop_front());
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] rd;
        logic [31:0] exp;
        logic [3:0]  strb;
        logic [5:0]  gidx;
        int          cyc;
        int          max_cyc;
        int          n;

        error_count = 0;
        check_count = 0;
        @(posedge clk_rv);
        @(negedge clk_rv);
        check_value("audio_lrck", 32'(audio_lrck), 32'd0);
        @(posedge clk_rv);
        vb_rst <= 1'b0;
        @(negedge clk_rv);
        check_value("irq", 32'(irq), 32'd0);
        check_value("led_red_n", 32'(led_red_n), 32'd1);
        check_value("led_green_n", 32'(led_green_n), 32'd1);
        check_value("core_hold", 32'(core_hold), 32'd1);
        check_value("key", 32'(key), 32'd0);
        n = 0;
        while (frames_seen == 0 && n < 400) begin
            @(negedge clk_rv);
            n++;
        end
        if (frames_seen == 0) timeout_fail("first audio frame");
        check_value("silent frame", last_frame, 32'd0);

        // RAM, fill every word then random strobed writes and echoed reads
        for (int i = 0; i < `PANO_RAM_WORDS; i++) begin
            wdata = rand_bits(32);
            ram_model[i] = wdata;
            bus_access(`PANO_RAM_BASE + 32'(i * 4), wdata, 4'hF, rd, cyc);
        end
        for (int i = 0; i < 300; i++) begin
            addr  = `PANO_RAM_BASE | {16'd0, 14'(rand_bits(14)), 2'b00};
            wdata = rand_bits(32);
            strb  = 4'(rand_bits(4));
            bus_access(addr, wdata, strb, rd, cyc);
            check_value("ram write cycles", cyc, 1);
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) ram_model[addr[12:2]][8*b +: 8] = wdata[8*b +: 8];
            end
            addr = `PANO_RAM_BASE | {16'd0, 14'(rand_bits(14)), 2'b00};
            bus_access(addr, 32'd0, 4'h0, rd, cyc);
            check_value("ram read cycles", cyc, 1);
            check_value("rsp.rdata", rd, ram_model[addr[12:2]]);
        end
        bus_idle();

        // GPIO control registers
        gpio_model[0] = 8'd0;
        gpio_model[1] = 8'd0;
        gpio_model[2] = 8'd1;
        gpio_model[3] = 8'd0;
        for (int i = 0; i < 100; i++) begin
            gidx  = 6'(rand_bits(2));
            wdata = rand_bits(32);
            bus_access(`PANO_GPIO_BASE + 32'(gidx * 4), wdata, 4'hF, rd, cyc);
            gpio_model[gidx[1:0]] = (gidx == 3) ? wdata[7:0] : {7'd0, wdata[0]};
            bus_idle();
            @(negedge clk_rv);
            check_value("led_green_n", 32'(led_green_n), 32'(!gpio_model[0][0]));
            check_value("led_red_n", 32'(led_red_n), 32'(!gpio_model[1][0]));
            check_value("core_hold", 32'(core_hold), 32'(gpio_model[2][0]));
            check_value("key", 32'(key), 32'(gpio_model[3]));
            gidx = 6'(rand_bits(6));
            exp  = (gidx < 4) ? 32'(gpio_model[gidx[1:0]]) : 32'd0;
            bus_access(`PANO_GPIO_BASE + 32'(gidx * 4), 32'd0, 4'h0, rd, cyc);
            check_value("gpio read cycles", cyc, 1);
            check_value("rsp.rdata", rd, exp);
            bus_idle();
        end

        // Unmapped accesses
        check_value("irq", 32'(irq), 32'd0);
        for (int i = 0; i < 10; i++) begin
            addr = {4'h1, 26'(rand_bits(26)), 2'b00};
            bus_access(addr, 32'd0, 4'h0, rd, cyc);
            check_value("rsp.rdata", rd, 32'hFFFFFFFF);
            bus_idle();
            @(negedge clk_rv);
            check_value("irq", 32'(irq), 32'd1);
        end

        // Audio frames with gaps, so silence falls in between
        for (int i = 0; i < 8; i++) begin
            wdata = rand_bits(32) | 32'h1;
            exp_q.push_back(wdata);
            bus_access(`PANO_GPIO_BASE + 32'(`PANO_GPIO_SAMPLE_IDX * 4),
                       wdata, 4'hF, rd, cyc);
            bus_idle();
            repeat (rand_bits(8)) @(posedge clk_rv);
        end
        wait_drain();

        // Back-pressure, six frames with no pause
        max_cyc = 0;
        for (int i = 0; i < 6; i++) begin
            wdata = rand_bits(32) | 32'h1;
            exp_q.push_back(wdata);
            bus_access(`PANO_GPIO_BASE + 32'(`PANO_GPIO_SAMPLE_IDX * 4),
                       wdata, 4'hF, rd, cyc);
            if (cyc > max_cyc) max_cyc = cyc;
        end
        bus_idle();
        check_count++;
        assert (max_cyc > 1) else begin
            error_count++;
            $display("six back to back sample writes were never stalled");
        end
        wait_drain();

        $display("checks=%0d errors=%0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== pano_soc.f ====
+incdir+common
common/pano_pkg.sv
verilog/soc_bus_decoder.sv
verilog/soc_ram.sv
gpio/gpio_regs.sv
audio/sample_fifo.sv
audio/dsp_serializer.sv
verilog/pano_soc_top.sv
tests/pano_soc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the pano_soc testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f pano_soc.f \
    --top-module pano_soc_tb \
    -o pano_soc_sim

./obj_dir/pano_soc_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
    echo "simulation did not complete"
    exit 1
fi
echo "simulation passed"
